// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // Data widths
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  mem_idx_t;

    // On-chip memory depth, 3 KB of 32-bit words
    localparam int MEM_WORDS = 768;

    // Address map
    // Interrupt handler lives at the bottom of the read-only region
    localparam xlen_t ROM_BASE = 64'h0000;
    localparam xlen_t ROM_SIZE = 64'h0400;
    // Reset PC and writable region
    localparam xlen_t RAM_BASE = 64'h0400;
    localparam xlen_t RAM_SIZE = 64'h0800;
    // Memory-mapped peripherals
    localparam xlen_t KEY_ADDR = 64'h2000;
    localparam xlen_t CON_ADDR = 64'h2008;

    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Full MRET encoding
    localparam instr_t MRET_WORD = 32'h3020_0073;

    // Execute phase of the core
    typedef enum logic [1:0] {exec, bubble, apb_setup, apb_access} core_state_t;

    // PS/2 frame deframer
    typedef enum logic [1:0] {idle, shift, stop} ps2_state_t;

endpackage

`default_nettype wire

// ==== ps2/ps2_receiver.sv ====
`default_nettype none

module ps2_receiver (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             ps2_clk,
    input  wire             ps2_dat,
    output soc_pkg::byte_t  code,
    output logic            code_valid
);
    import soc_pkg::*;

    // Two sync flops plus one for edge detect
    logic [2:0] clk_sync;
    logic [1:0] dat_sync;
    logic       fall;
    logic       dat;

    ps2_state_t state;
    logic [3:0] bit_cnt;
    // Eight data bits then parity, LSB first
    logic [8:0] shreg;
    // Set by F0, eats the next code
    logic       break_flag;

    assign fall = clk_sync[2] && !clk_sync[1];
    assign dat  = dat_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Lines idle high
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            bit_cnt    <= '0;
            break_flag <= 1'b0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (fall) begin
                case (state)
                    idle: begin
                        // Start bit must be low
                        if (!dat) begin
                            bit_cnt <= '0;
                            state   <= shift;
                        end
                    end
                    shift: begin
                        if (bit_cnt == 4'd8) begin
                            state <= stop;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    stop: begin
                        state <= idle;
                        // Stop bit high and odd parity over data plus parity
                        if (dat && ^shreg) begin
                            if (shreg[7:0] == 8'hF0) begin
                                break_flag <= 1'b1;
                            end else if (break_flag) begin
                                break_flag <= 1'b0;
                            end else begin
                                code_valid <= 1'b1;
                            end
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (fall && state == shift) begin
            shreg <= {dat, shreg[8:1]};
        end
        if (fall && state == stop) begin
            code <= shreg[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/key_irq.sv ====
`default_nettype none

module key_irq (
    input  wire             clk,
    input  wire             rst_n,
    input  soc_pkg::byte_t  code,
    input  wire             code_valid,
    input  wire             irq_ack,
    output soc_pkg::byte_t  key_code,
    output logic            irq
);

    logic new_key;
    // Zero is never a real make code
    assign new_key = code_valid && (code != 8'h00);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_code <= 8'h00;
            irq      <= 1'b0;
        end else begin
            // A newer key replaces an unserviced one
            if (new_key) begin
                key_code <= code;
                irq      <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/unified_mem.sv ====
`default_nettype none

module unified_mem (
    input  wire                 clk,
    input  soc_pkg::mem_idx_t   fetch_addr,
    output soc_pkg::instr_t     fetch_data,
    input  soc_pkg::mem_idx_t   data_addr,
    input  wire                 data_we,
    input  soc_pkg::instr_t     data_wdata,
    output soc_pkg::instr_t     data_rdata
);
    import soc_pkg::*;

    // Instructions and data share one array
    instr_t mem [MEM_WORDS];

    // Handler and main program come from the image
    initial begin
        $readmemh("rom.hex", mem);
    end

    // Instruction port, read only
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_addr];
    end

    // Data port
    // Read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (data_we) begin
            mem[data_addr] <= data_wdata;
        end
        data_rdata <= mem[data_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/apb_fabric.sv ====
`default_nettype none

module apb_fabric (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 psel,
    input  wire                 penable,
    input  wire                 pwrite,
    input  soc_pkg::xlen_t      paddr,
    input  soc_pkg::xlen_t      pwdata,
    output soc_pkg::xlen_t      prdata,
    output logic                pready,
    output logic                pslverr,
    output soc_pkg::mem_idx_t   mem_addr,
    output logic                mem_we,
    output soc_pkg::instr_t     mem_wdata,
    input  soc_pkg::instr_t     mem_rdata,
    input  soc_pkg::byte_t      key_code,
    output soc_pkg::byte_t      con_data,
    output logic                con_valid
);
    import soc_pkg::*;

    // Target decode
    logic rom_sel;
    logic ram_sel;
    logic key_sel;
    logic con_sel;
    logic hit;
    assign rom_sel = paddr < (ROM_BASE + ROM_SIZE);
    assign ram_sel = (paddr >= RAM_BASE) && (paddr < (RAM_BASE + RAM_SIZE));
    assign key_sel = paddr == KEY_ADDR;
    assign con_sel = paddr == CON_ADDR;
    assign hit     = rom_sel || ram_sel || key_sel || con_sel;

    logic access;
    assign access = psel && penable;

    // No wait states for any target
    assign pready  = access;
    assign pslverr = access && !hit;

    // Address already valid in setup, so read data is ready in access
    assign mem_addr  = paddr[11:2];
    assign mem_wdata = pwdata[31:0];
    // Handler region is read-only
    assign mem_we    = access && pwrite && ram_sel;

    // Read mux, zero on writes, idle cycles and misses
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (rom_sel || ram_sel) begin
                prdata = {32'h0, mem_rdata};
            end else if (key_sel) begin
                prdata = {56'h0, key_code};
            end
        end
    end

    // Console strobe, one per access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            con_valid <= 1'b0;
        end else begin
            con_valid <= access && pwrite && con_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (access && pwrite && con_sel) begin
            con_data <= pwdata[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== cpu/rv_core.sv ====
`default_nettype none

module rv_core (
    input  wire                 clk,
    input  wire                 rst_n,
    output soc_pkg::mem_idx_t   fetch_addr,
    input  soc_pkg::instr_t     fetch_data,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output soc_pkg::xlen_t      paddr,
    output soc_pkg::xlen_t      pwdata,
    input  soc_pkg::xlen_t      prdata,
    input  wire                 pready,
    input  wire                 pslverr,
    input  wire                 irq,
    output logic                irq_ack,
    output soc_pkg::instr_t     ir,
    output logic                heartbeat
);
    import soc_pkg::*;

    xlen_t       pc;
    xlen_t       mepc;
    logic        handler_active;
    core_state_t state;
    logic [4:0]  ld_rd;

    // Register file, x0 never written
    xlen_t regs [32];

    // Memory output register acts as the instruction register
    assign ir = fetch_data;
    // PC points one word past the instruction in execute
    assign fetch_addr = pc[11:2];

    // Field extraction
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    // Immediates, all sign-extended
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_u;
    xlen_t imm_j;
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'h000};
    assign imm_j = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    xlen_t rs1_val;
    xlen_t rs2_val;
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Interrupt only at a boundary and never nested
    logic take_irq;
    assign take_irq = irq && !handler_active;

    // Writeback selection
    logic       wb_en;
    logic [4:0] wb_addr;
    xlen_t      wb_data;

    always_comb begin
        wb_en   = 1'b0;
        wb_addr = rd;
        wb_data = '0;
        if (state == exec && !take_irq) begin
            case (opcode)
                OP_LUI: begin
                    wb_en   = 1'b1;
                    wb_data = imm_u;
                end
                OP_OPIMM: begin
                    // ADDI only
                    wb_en   = (funct3 == 3'b000);
                    wb_data = rs1_val + imm_i;
                end
                OP_JAL: begin
                    // Link is the address after the jump
                    wb_en   = 1'b1;
                    wb_data = pc;
                end
                default: ;
            endcase
        end else if (state == apb_access && pready && !pwrite) begin
            wb_en   = 1'b1;
            wb_addr = ld_rd;
            // Failed load writes zero
            wb_data = pslverr ? '0 : {{32{prdata[31]}}, prdata[31:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en && wb_addr != 5'd0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc             <= RAM_BASE;
            mepc           <= '0;
            handler_active <= 1'b0;
            // Fetch output is stale straight after reset
            state          <= bubble;
            psel           <= 1'b0;
            penable        <= 1'b0;
            pwrite         <= 1'b0;
            irq_ack        <= 1'b0;
            heartbeat      <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
            irq_ack   <= 1'b0;
            case (state)
                bubble: begin
                    // Drop the wrong-path fetch
                    pc    <= pc + 64'd4;
                    state <= exec;
                end
                exec: begin
                    if (take_irq) begin
                        // Resume at the instruction that was skipped
                        mepc           <= pc - 64'd4;
                        pc             <= ROM_BASE;
                        irq_ack        <= 1'b1;
                        handler_active <= 1'b1;
                        state          <= bubble;
                    end else begin
                        pc <= pc + 64'd4;
                        case (opcode)
                            OP_JAL: begin
                                pc    <= pc - 64'd4 + imm_j;
                                state <= bubble;
                            end
                            OP_SYSTEM: begin
                                if (ir == MRET_WORD) begin
                                    pc             <= mepc;
                                    handler_active <= 1'b0;
                                    state          <= bubble;
                                end
                            end
                            OP_LOAD: begin
                                if (funct3 == 3'b010) begin
                                    // Hold PC so the next fetch stays valid
                                    pc     <= pc;
                                    paddr  <= rs1_val + imm_i;
                                    pwrite <= 1'b0;
                                    psel   <= 1'b1;
                                    ld_rd  <= rd;
                                    state  <= apb_setup;
                                end
                            end
                            OP_STORE: begin
                                if (funct3 == 3'b010) begin
                                    pc     <= pc;
                                    paddr  <= rs1_val + imm_s;
                                    pwdata <= rs2_val;
                                    pwrite <= 1'b1;
                                    psel   <= 1'b1;
                                    state  <= apb_setup;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                apb_setup: begin
                    penable <= 1'b1;
                    state   <= apb_access;
                end
                apb_access: begin
                    // Wait as long as the completer needs
                    if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        pwrite  <= 1'b0;
                        pc      <= pc + 64'd4;
                        state   <= exec;
                    end
                end
                default: state <= bubble;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/soc_top.sv ====
`default_nettype none

module soc_top (
    input  wire             CLOCK_50,
    input  wire             KEY0,
    input  wire             ps2_clk,
    input  wire             ps2_dat,
    output soc_pkg::byte_t  ledg,
    output logic [5:0]      ledr_pc,
    output logic            heartbeat,
    output logic            irq_led,
    output soc_pkg::byte_t  con_data,
    output logic            con_valid
);
    import soc_pkg::*;

    // Instruction side
    mem_idx_t fetch_addr;
    instr_t   fetch_data;
    instr_t   ir;

    // APB
    logic  psel;
    logic  penable;
    logic  pwrite;
    xlen_t paddr;
    xlen_t pwdata;
    xlen_t prdata;
    logic  pready;
    logic  pslverr;

    // Memory data port
    mem_idx_t mem_addr;
    logic     mem_we;
    instr_t   mem_wdata;
    instr_t   mem_rdata;

    // Keyboard and interrupt
    byte_t code;
    logic  code_valid;
    byte_t key_code;
    logic  irq;
    logic  irq_ack;

    rv_core u_rv_core (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .irq        (irq),
        .irq_ack    (irq_ack),
        .ir         (ir),
        .heartbeat  (heartbeat)
    );

    unified_mem u_unified_mem (
        .clk        (CLOCK_50),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_addr  (mem_addr),
        .data_we    (mem_we),
        .data_wdata (mem_wdata),
        .data_rdata (mem_rdata)
    );

    apb_fabric u_apb_fabric (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .key_code   (key_code),
        .con_data   (con_data),
        .con_valid  (con_valid)
    );

    ps2_receiver u_ps2_receiver (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .code       (code),
        .code_valid (code_valid)
    );

    key_irq u_key_irq (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .code       (code),
        .code_valid (code_valid),
        .irq_ack    (irq_ack),
        .key_code   (key_code),
        .irq        (irq)
    );

    // Debug LEDs
    assign ledg    = ir[7:0];
    assign ledr_pc = fetch_addr[5:0];
    assign irq_led = irq;

endmodule

`default_nettype wire

// ==== test/tb_soc.sv ====
`default_nettype none

module tb_soc;
    timeunit 1ns;
    timeprecision 1ps;

    import soc_pkg::*;

    // Wait limits and PS/2 pacing in clock cycles
    localparam int wait_limit   = 2000;
    localparam int quiet_window = 400;
    localparam int ps2_half_bit = 8;
    localparam int key_count    = 4;
    // Low bits of the reset PC word index shown on the LEDs
    localparam logic [5:0] reset_led_pc = RAM_BASE[7:2];
    // Main program starts with lui x1 0x2
    localparam instr_t main_entry_word = 32'h000020B7;

    logic       CLOCK_50;
    logic       KEY0;
    logic       ps2_clk;
    logic       ps2_dat;
    byte_t      ledg;
    logic [5:0] ledr_pc;
    logic       heartbeat;
    logic       irq_led;
    byte_t      con_data;
    logic       con_valid;

    // Monitor state
    byte_t con_q [$];
    int    irq_rises;
    logic  irq_seen;

    // Heartbeat reference
    logic [1:0] hb_cnt;
    logic       hb_prev;

    int     errors;
    int     hb_errors;
    int     tests_passed;
    int     tests_failed;
    int     test_start_errors;
    integer seed;

    soc_top u_soc_top (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .ledg      (ledg),
        .ledr_pc   (ledr_pc),
        .heartbeat (heartbeat),
        .irq_led   (irq_led),
        .con_data  (con_data),
        .con_valid (con_valid)
    );

    // 50 MHz
    always #10 CLOCK_50 = ~CLOCK_50;

    // Console bytes and irq edges sampled away from the active edge
    always @(negedge CLOCK_50) begin
        if (con_valid) begin
            con_q.push_back(con_data);
        end
        if (irq_led && !irq_seen) begin
            irq_rises = irq_rises + 1;
        end
        irq_seen = irq_led;
    end

    // Arms the heartbeat check once two toggles exist to compare
    always @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            hb_cnt <= 2'd0;
        end else if (hb_cnt != 2'd3) begin
            hb_cnt <= hb_cnt + 2'd1;
        end
    end

    always @(posedge CLOCK_50) begin
        hb_prev <= heartbeat;
    end

    heartbeat_toggles: assert property (@(posedge CLOCK_50)
        (hb_cnt >= 2'd2) |-> (heartbeat != hb_prev))
    else begin
        $display("CHECK FAILED at %0t: heartbeat = %b, expected %b",
                 $time, $sampled(heartbeat), ~$sampled(hb_prev));
        hb_errors++;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reset_outputs();
        check_value("con_valid", 64'(con_valid), 64'(0));
        check_value("irq_led", 64'(irq_led), 64'(0));
        check_value("ledr_pc", 64'(ledr_pc), 64'(reset_led_pc));
    endtask

    // Random make code other than 00 and the break prefix
    task automatic draw_code(output byte_t code);
        logic [31:0] rnd;
        code = 8'h00;
        while (code == 8'h00 || code == 8'hF0) begin
            rnd  = $random(seed);
            code = rnd[7:0];
        end
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_ps2_frame(input byte_t data, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        int          i;
        parity = ~^data;
        if (bad_parity) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(posedge CLOCK_50);
            ps2_dat <= frame[i];
            repeat (ps2_half_bit) @(posedge CLOCK_50);
            // Receiver samples on this edge
            ps2_clk <= 1'b0;
            repeat (ps2_half_bit) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
        @(posedge CLOCK_50);
        ps2_dat <= 1'b1;
        repeat (2 * ps2_half_bit) @(posedge CLOCK_50);
    endtask

    task automatic wait_irq_rises(input int target);
        int cycles;
        cycles = 0;
        while (irq_rises < target && cycles < wait_limit) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        if (irq_rises < target) begin
            $display("Timeout at %0t: irq_led did not rise within %0d cycles",
                     $time, wait_limit);
            errors++;
        end
    endtask

    task automatic wait_console_bytes(input int count);
        int cycles;
        cycles = 0;
        while (con_q.size() < count && cycles < wait_limit) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        if (con_q.size() < count) begin
            $display("Timeout at %0t: only %0d of %0d console bytes arrived",
                     $time, con_q.size(), count);
            errors++;
        end
    endtask

    task automatic wait_irq_low();
        int cycles;
        cycles = 0;
        while (irq_seen && cycles < wait_limit) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        if (irq_seen) begin
            $display("Timeout at %0t: irq_led stayed high after the echo", $time);
            errors++;
        end
    endtask

    // One key press, one interrupt, one echoed byte
    task automatic check_key_echo(input byte_t code);
        int rises_before;
        rises_before = irq_rises;
        send_ps2_frame(code, 1'b0);
        wait_irq_rises(rises_before + 1);
        wait_console_bytes(1);
        if (con_q.size() > 0) begin
            check_value("con_data", 64'(con_q.pop_front()), 64'(code));
        end
        wait_irq_low();
    endtask

    task automatic report_test(input string name, input int new_errors);
        if (new_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, new_errors);
        end
    endtask

    initial begin
        byte_t code;
        byte_t banner [3];
        int    rises_before;
        int    bytes_before;
        int    i;

        CLOCK_50     = 1'b0;
        KEY0         = 1'b0;
        ps2_clk      = 1'b1;
        ps2_dat      = 1'b1;
        seed         = 32'hd4cdfb38;
        errors       = 0;
        hb_errors    = 0;
        tests_passed = 0;
        tests_failed = 0;
        irq_rises    = 0;
        irq_seen     = 1'b0;
        banner[0]    = "O";
        banner[1]    = "K";
        banner[2]    = 8'h0A;

        // Reset values during reset and right after release
        test_start_errors = errors;
        repeat (8) begin
            @(negedge CLOCK_50);
            check_reset_outputs();
        end
        @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(negedge CLOCK_50);
        check_reset_outputs();
        // Instruction register holds the word at the reset PC
        check_value("ledg", 64'(ledg), 64'(main_entry_word[7:0]));
        report_test("reset values", errors - test_start_errors);

        // Banner from the main program and nothing after it
        test_start_errors = errors;
        wait_console_bytes(3);
        repeat (quiet_window) @(posedge CLOCK_50);
        check_value("con_valid pulses", 64'(con_q.size()), 64'(3));
        for (i = 0; i < 3; i++) begin
            if (con_q.size() > 0) begin
                check_value("con_data", 64'(con_q.pop_front()), 64'(banner[i]));
            end
        end
        con_q.delete();
        report_test("main program output", errors - test_start_errors);

        // Echo of random make codes
        test_start_errors = errors;
        repeat (key_count) begin
            draw_code(code);
            check_key_echo(code);
        end
        report_test("key echo", errors - test_start_errors);

        // F0 swallows the code after it
        test_start_errors = errors;
        draw_code(code);
        rises_before = irq_rises;
        bytes_before = con_q.size();
        send_ps2_frame(8'hF0, 1'b0);
        send_ps2_frame(code, 1'b0);
        repeat (quiet_window) @(posedge CLOCK_50);
        check_value("con_valid pulses", 64'(con_q.size()), 64'(bytes_before));
        check_value("irq_led rises", 64'(irq_rises), 64'(rises_before));
        report_test("break code", errors - test_start_errors);

        // Bad frame dropped and receiver still in sync afterwards
        test_start_errors = errors;
        draw_code(code);
        rises_before = irq_rises;
        bytes_before = con_q.size();
        send_ps2_frame(code, 1'b1);
        repeat (quiet_window) @(posedge CLOCK_50);
        check_value("con_valid pulses", 64'(con_q.size()), 64'(bytes_before));
        check_value("irq_led rises", 64'(irq_rises), 64'(rises_before));
        draw_code(code);
        check_key_echo(code);
        report_test("bad parity", errors - test_start_errors);

        report_test("heartbeat", hb_errors);

        $display("Tests: %0d passed, %0d failed, %0d failed checks",
                 tests_passed, tests_failed, errors + hb_errors);
        if (tests_failed == 0 && errors + hb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/rom.hex ====
// One 32-bit instruction word per line, @ sets the word index
// Handler at word 000, main program at word 100 (byte address 0x400)
@000
000021B7  // lui  x3, 0x2
0001A203  // lw   x4, 0(x3)
0041A423  // sw   x4, 8(x3)
30200073  // mret
@100
000020B7  // lui  x1, 0x2
04F00113  // addi x2, x0, 0x4F
0020A423  // sw   x2, 8(x1)
04B00113  // addi x2, x0, 0x4B
0020A423  // sw   x2, 8(x1)
00A00113  // addi x2, x0, 0x0A
0020A423  // sw   x2, 8(x1)
0000006F  // jal  x0, 0

// ==== vlog.f ====
common/soc_pkg.sv
ps2/ps2_receiver.sv
verilog/key_irq.sv
verilog/unified_mem.sv
verilog/apb_fabric.sv
cpu/rv_core.sv
verilog/soc_top.sv
test/tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, then run from test/ where the memory image lives
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_soc -f vlog.f -o tb_soc \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
(cd test && ../obj_dir/tb_soc) > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation gave no result"; exit 1; }
echo "Simulation passed"
